// File: verilog/cam_pkg.sv
package cam_pkg;

  localparam int frame_w   = 8;
  localparam int frame_h   = 4;
  localparam int pix_count = frame_w * frame_h;
  localparam int addr_w    = 5;
  localparam int pix_w     = 12;  // rgb444, red in the high nibble

  typedef logic [pix_w-1:0]  pix_t;
  typedef logic [addr_w-1:0] addr_t;

  localparam addr_t last_addr = addr_t'(pix_count - 1);

  typedef struct packed {
    logic  en;
    addr_t addr;
    pix_t  data;
  } buf_wr_t;

  typedef enum logic [1:0] {cmd_live, cmd_snapshot, cmd_gray, cmd_edge} cam_cmd_e;

  typedef enum logic [1:0] {st_idle, st_run, st_flush, st_done} engine_state_e;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  localparam logic [3:0] reg_ctrl     = 4'h0;
  localparam logic [3:0] reg_status   = 4'h4;
  localparam logic [3:0] reg_pix_addr = 4'h8;
  localparam logic [3:0] reg_pix_data = 4'hc;

  // (r + 2g + b) / 4, always fits a nibble
  function automatic logic [3:0] to_gray(pix_t p);
    logic [5:0] sum;
    sum = {2'b00, p[11:8]} + {1'b0, p[7:4], 1'b0} + {2'b00, p[3:0]};
    return sum[5:2];
  endfunction

endpackage

// File: verilog/frame_buffer.sv
`timescale 1ns/100ps

module frame_buffer (
  input  logic             clk_100,
  input  cam_pkg::buf_wr_t wr_i,
  input  cam_pkg::addr_t   rd_addr_i,
  output cam_pkg::pix_t    rd_data_o
);

  cam_pkg::pix_t mem [cam_pkg::pix_count];

  always_ff @(posedge clk_100) begin
    if (wr_i.en) begin
      mem[wr_i.addr] <= wr_i.data;
    end
    rd_data_o <= mem[rd_addr_i];  // old data on a same-address write
  end

endmodule

// File: verilog/pixel_capture.sv
`timescale 1ns/100ps

module pixel_capture (
  input  logic             clk_100,
  input  logic             reset_global,
  input  logic             frame_start_i,
  input  logic             pix_valid_i,
  input  cam_pkg::pix_t    pix_data_i,
  input  logic             enable_i,
  output cam_pkg::buf_wr_t wr_o
);

  logic [cam_pkg::addr_w:0] cnt;  // msb set once the frame is full
  logic                     take;

  assign take = pix_valid_i & ~cnt[cam_pkg::addr_w] & ~frame_start_i;

  always_ff @(posedge clk_100) begin
    if (reset_global) begin
      cnt <= '0;
    end else if (frame_start_i) begin
      cnt <= '0;
    end else if (take) begin
      cnt <= cnt + 1'b1;  // counts even when blocked so raster order holds
    end
  end

  // blocked pixels are simply dropped
  assign wr_o = '{en: take & enable_i, addr: cnt[cam_pkg::addr_w-1:0], data: pix_data_i};

  // the camera sends no pixel in the frame start cycle
  assert property (@(posedge clk_100) disable iff (reset_global)
    frame_start_i |-> !pix_valid_i);

endmodule

// File: verilog/snapshot_copy.sv
`timescale 1ns/100ps

module snapshot_copy (
  input  logic             clk_100,
  input  logic             reset_global,
  input  logic             start_i,
  output cam_pkg::addr_t   rd_addr_o,
  input  cam_pkg::pix_t    rd_data_i,
  output cam_pkg::buf_wr_t wr_o,
  output logic             done_o
);

  cam_pkg::engine_state_e state;
  cam_pkg::addr_t         cnt;
  cam_pkg::addr_t         addr_d1;
  cam_pkg::addr_t         addr_d2;
  logic                   vld_d1;
  logic                   vld_d2;

  always_ff @(posedge clk_100) begin
    if (reset_global) begin
      state  <= cam_pkg::st_idle;
      cnt    <= '0;
      vld_d1 <= 1'b0;
      vld_d2 <= 1'b0;
    end else begin
      vld_d1 <= state == cam_pkg::st_run;
      vld_d2 <= vld_d1;
      case (state)
        cam_pkg::st_idle: begin
          if (start_i) begin
            state <= cam_pkg::st_run;
            cnt   <= '0;
          end
        end
        cam_pkg::st_run: begin
          cnt <= cnt + 1'b1;
          if (cnt == cam_pkg::last_addr) state <= cam_pkg::st_flush;
        end
        cam_pkg::st_flush: if (!vld_d1) state <= cam_pkg::st_done;  // last read back
        default: state <= cam_pkg::st_idle;
      endcase
    end
  end

  // arbiter + ram latency
  always_ff @(posedge clk_100) begin
    addr_d1 <= cnt;
    addr_d2 <= addr_d1;
  end

  assign rd_addr_o = cnt;
  assign wr_o      = '{en: vld_d2, addr: addr_d2, data: rd_data_i};
  assign done_o    = state == cam_pkg::st_done;

  // host must not relaunch a running copy
  assert property (@(posedge clk_100) disable iff (reset_global)
    start_i |-> state == cam_pkg::st_idle);

endmodule

// File: verilog/gray_filter.sv
`timescale 1ns/100ps

module gray_filter (
  input  logic             clk_100,
  input  logic             reset_global,
  input  logic             start_i,
  output cam_pkg::addr_t   rd_addr_o,
  input  cam_pkg::pix_t    rd_data_i,
  output cam_pkg::buf_wr_t wr_o,
  output logic             done_o
);

  cam_pkg::engine_state_e state;
  cam_pkg::addr_t         cnt;
  cam_pkg::addr_t         addr_d1;
  cam_pkg::addr_t         addr_d2;
  logic                   vld_d1;
  logic                   vld_d2;
  logic [3:0]             g;

  always_ff @(posedge clk_100) begin
    if (reset_global) begin
      state  <= cam_pkg::st_idle;
      cnt    <= '0;
      vld_d1 <= 1'b0;
      vld_d2 <= 1'b0;
    end else begin
      vld_d1 <= state == cam_pkg::st_run;
      vld_d2 <= vld_d1;
      case (state)
        cam_pkg::st_idle: begin
          if (start_i) begin
            state <= cam_pkg::st_run;
            cnt   <= '0;
          end
        end
        cam_pkg::st_run: begin
          cnt <= cnt + 1'b1;
          if (cnt == cam_pkg::last_addr) state <= cam_pkg::st_flush;
        end
        cam_pkg::st_flush: if (!vld_d1) state <= cam_pkg::st_done;
        default: state <= cam_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_100) begin
    addr_d1 <= cnt;
    addr_d2 <= addr_d1;
  end

  // each address is read three cycles before its write lands
  assign g         = cam_pkg::to_gray(rd_data_i);
  assign rd_addr_o = cnt;
  assign wr_o      = '{en: vld_d2, addr: addr_d2, data: {g, g, g}};
  assign done_o    = state == cam_pkg::st_done;

endmodule

// File: verilog/edge_filter.sv
`timescale 1ns/100ps

module edge_filter (
  input  logic             clk_100,
  input  logic             reset_global,
  input  logic             start_i,
  output cam_pkg::addr_t   rd_addr_o,
  input  cam_pkg::pix_t    rd_data_i,
  output cam_pkg::buf_wr_t wr_o,
  output logic             done_o
);

  cam_pkg::engine_state_e state;
  cam_pkg::addr_t         pix_addr;
  logic [2:0]             ph;  // per-pixel phase 0..4
  logic [3:0]             g_c;
  logic [3:0]             g_r;
  logic [3:0]             g_b;
  logic [3:0]             d_r;
  logic [3:0]             d_b;
  logic [4:0]             sum;
  logic [3:0]             mag;
  logic                   border;

  always_ff @(posedge clk_100) begin
    if (reset_global) begin
      state    <= cam_pkg::st_idle;
      pix_addr <= '0;
      ph       <= '0;
    end else begin
      case (state)
        cam_pkg::st_idle: begin
          if (start_i) begin
            state    <= cam_pkg::st_run;
            pix_addr <= '0;
            ph       <= '0;
          end
        end
        cam_pkg::st_run: begin
          ph <= ph + 1'b1;
          if (ph == 3'd4) begin
            ph       <= '0;
            pix_addr <= pix_addr + 1'b1;
            if (pix_addr == cam_pkg::last_addr) state <= cam_pkg::st_flush;
          end
        end
        cam_pkg::st_flush: state <= cam_pkg::st_done;  // let the last write land
        default: state <= cam_pkg::st_idle;
      endcase
    end
  end

  // center, then right neighbour, then the pixel below
  always_comb begin
    case (ph)
      3'd0:    rd_addr_o = pix_addr;
      3'd1:    rd_addr_o = pix_addr + 1'b1;
      default: rd_addr_o = pix_addr + cam_pkg::addr_t'(cam_pkg::frame_w);
    endcase
  end

  // reads come back two phases later
  always_ff @(posedge clk_100) begin
    if (ph == 3'd2) g_c <= cam_pkg::to_gray(rd_data_i);
    if (ph == 3'd3) g_r <= cam_pkg::to_gray(rd_data_i);
  end

  assign g_b    = cam_pkg::to_gray(rd_data_i);
  assign d_r    = (g_c > g_r) ? g_c - g_r : g_r - g_c;
  assign d_b    = (g_c > g_b) ? g_c - g_b : g_b - g_c;
  assign sum    = {1'b0, d_r} + {1'b0, d_b};
  assign border = pix_addr[2:0] == 3'(cam_pkg::frame_w - 1)
                  || pix_addr[4:3] == 2'(cam_pkg::frame_h - 1);
  assign mag    = border ? 4'd0 : (sum[4] ? 4'hf : sum[3:0]);  // saturate at 15

  assign wr_o   = '{en: state == cam_pkg::st_run && ph == 3'd4, addr: pix_addr,
                    data: {mag, mag, mag}};
  assign done_o = state == cam_pkg::st_done;

endmodule

// File: verilog/buffer_arbiter.sv
`timescale 1ns/100ps

module buffer_arbiter (
  input  logic              clk_100,
  input  logic              reset_global,
  input  cam_pkg::cam_cmd_e cmd_i,
  input  logic              busy_i,
  input  cam_pkg::buf_wr_t  cap_wr_i,
  input  cam_pkg::buf_wr_t  snap_wr_i,
  input  cam_pkg::addr_t    snap_rd_addr_i,
  input  cam_pkg::buf_wr_t  gray_wr_i,
  input  cam_pkg::addr_t    gray_rd_addr_i,
  input  cam_pkg::buf_wr_t  edge_wr_i,
  input  cam_pkg::addr_t    edge_rd_addr_i,
  input  cam_pkg::addr_t    rb_addr_i,
  input  logic              rb_sel_i,
  output cam_pkg::buf_wr_t  buf1_wr_o,
  output cam_pkg::addr_t    buf1_rd_addr_o,
  output cam_pkg::buf_wr_t  buf2_wr_o,
  output cam_pkg::addr_t    buf2_rd_addr_o,
  output cam_pkg::pix_t     rd_data_o,
  input  cam_pkg::pix_t     buf1_data_i,
  input  cam_pkg::pix_t     buf2_data_i
);

  cam_pkg::cam_cmd_e owner;
  cam_pkg::buf_wr_t  buf1_wr_n;
  cam_pkg::buf_wr_t  buf2_wr_n;
  cam_pkg::addr_t    buf1_rd_n;
  cam_pkg::addr_t    buf2_rd_n;
  logic              rb_sel_q;

  assign owner = busy_i ? cmd_i : cam_pkg::cmd_live;  // live once done

  always_comb begin
    buf1_wr_n    = cap_wr_i;
    buf1_wr_n.en = 1'b0;
    buf2_wr_n    = snap_wr_i;
    buf2_wr_n.en = 1'b0;
    buf1_rd_n    = rb_addr_i;
    buf2_rd_n    = rb_addr_i;
    case (owner)
      cam_pkg::cmd_live: buf1_wr_n = cap_wr_i;
      cam_pkg::cmd_snapshot: begin
        buf1_rd_n = snap_rd_addr_i;
        buf2_wr_n = snap_wr_i;
      end
      cam_pkg::cmd_gray: begin
        buf2_rd_n = gray_rd_addr_i;
        buf2_wr_n = gray_wr_i;
      end
      default: begin
        buf2_rd_n = edge_rd_addr_i;
        buf2_wr_n = edge_wr_i;
      end
    endcase
  end

  always_ff @(posedge clk_100) begin
    buf1_wr_o      <= buf1_wr_n;
    buf2_wr_o      <= buf2_wr_n;
    buf1_rd_addr_o <= buf1_rd_n;
    buf2_rd_addr_o <= buf2_rd_n;
    rb_sel_q       <= rb_sel_i;  // lines up with the ram read
    if (reset_global) begin
      buf1_wr_o.en <= 1'b0;
      buf2_wr_o.en <= 1'b0;
    end
  end

  assign rd_data_o = rb_sel_q ? buf2_data_i : buf1_data_i;

  // capture and the engines never write in the same cycle
  assert property (@(posedge clk_100) disable iff (reset_global)
    $onehot0({cap_wr_i.en, snap_wr_i.en, gray_wr_i.en, edge_wr_i.en}));

endmodule

// File: verilog/cam_apb_regs.sv
`timescale 1ns/100ps

module cam_apb_regs (
  input  logic              clk_100,
  input  logic              reset_global,
  input  cam_pkg::apb_req_t apb_req_i,
  output cam_pkg::apb_rsp_t apb_rsp_o,
  input  logic              done_snap_i,
  input  logic              done_gray_i,
  input  logic              done_edge_i,
  output cam_pkg::cam_cmd_e cmd_o,
  output logic              busy_o,
  output logic              start_snap_o,
  output logic              start_gray_o,
  output logic              start_edge_o,
  output cam_pkg::addr_t    rb_addr_o,
  output logic              rb_sel_o,
  input  cam_pkg::pix_t     rb_data_i,
  output logic              done_o
);

  logic              access;
  logic              pix_rd;
  logic              wait_q;
  logic              wr_fire;
  logic              ctrl_wr;
  cam_pkg::cam_cmd_e new_cmd;
  logic [31:0]       rdata;

  assign access  = apb_req_i.psel & apb_req_i.penable;
  assign pix_rd  = !apb_req_i.pwrite && apb_req_i.paddr == cam_pkg::reg_pix_data;
  assign ctrl_wr = apb_req_i.pwrite && apb_req_i.paddr == cam_pkg::reg_ctrl;
  assign wr_fire = access & apb_req_i.pwrite;  // writes finish in the first access cycle
  assign new_cmd = cam_pkg::cam_cmd_e'(apb_req_i.pwdata[1:0]);

  // pixel reads wait one access cycle for the buffer
  assign apb_rsp_o.pready  = access & (!pix_rd | wait_q);
  assign apb_rsp_o.pslverr = access & ctrl_wr & busy_o;
  assign apb_rsp_o.prdata  = rdata;

  always_comb begin
    case (apb_req_i.paddr)
      cam_pkg::reg_ctrl:     rdata = {30'd0, cmd_o};
      cam_pkg::reg_status:   rdata = {30'd0, done_o, busy_o};
      cam_pkg::reg_pix_addr: rdata = {23'd0, rb_sel_o, 3'd0, rb_addr_o};
      cam_pkg::reg_pix_data: rdata = {20'd0, rb_data_i};
      default:               rdata = 32'd0;
    endcase
  end

  always_ff @(posedge clk_100) begin
    if (reset_global) begin
      wait_q       <= 1'b0;
      cmd_o        <= cam_pkg::cmd_live;
      busy_o       <= 1'b0;
      done_o       <= 1'b0;
      start_snap_o <= 1'b0;
      start_gray_o <= 1'b0;
      start_edge_o <= 1'b0;
      rb_addr_o    <= '0;
      rb_sel_o     <= 1'b0;
    end else begin
      wait_q       <= access & pix_rd & !wait_q;
      start_snap_o <= 1'b0;
      start_gray_o <= 1'b0;
      start_edge_o <= 1'b0;
      if (done_snap_i | done_gray_i | done_edge_i) begin
        busy_o <= 1'b0;
        done_o <= 1'b1;  // sticky
      end
      if (wr_fire && ctrl_wr && !busy_o) begin
        cmd_o        <= new_cmd;
        done_o       <= 1'b0;
        busy_o       <= new_cmd != cam_pkg::cmd_live;
        start_snap_o <= new_cmd == cam_pkg::cmd_snapshot;
        start_gray_o <= new_cmd == cam_pkg::cmd_gray;
        start_edge_o <= new_cmd == cam_pkg::cmd_edge;
      end
      if (wr_fire && apb_req_i.paddr == cam_pkg::reg_pix_addr) begin
        rb_addr_o <= apb_req_i.pwdata[cam_pkg::addr_w-1:0];
        rb_sel_o  <= apb_req_i.pwdata[8];  // 1 selects buffer 2
      end
    end
  end

endmodule

// File: verilog/cam_top.sv
`timescale 1ns/100ps

module cam_top (
  input  logic              clk_100,
  input  logic              reset_global,
  input  cam_pkg::apb_req_t apb_req_i,
  output cam_pkg::apb_rsp_t apb_rsp_o,
  input  logic              frame_start_i,
  input  logic              pix_valid_i,
  input  cam_pkg::pix_t     pix_data_i,
  output logic              done_o
);

  cam_pkg::cam_cmd_e cmd;
  logic              busy;
  logic              start_snap, start_gray, start_edge;
  logic              done_snap, done_gray, done_edge;
  cam_pkg::buf_wr_t  cap_wr, snap_wr, gray_wr, edge_wr;
  cam_pkg::addr_t    snap_rd, gray_rd, edge_rd;
  cam_pkg::buf_wr_t  buf1_wr, buf2_wr;
  cam_pkg::addr_t    buf1_rd, buf2_rd;
  cam_pkg::pix_t     buf1_q, buf2_q;
  cam_pkg::addr_t    rb_addr;
  logic              rb_sel;
  cam_pkg::pix_t     rb_data;

  cam_apb_regs u_regs (
    .clk_100, .reset_global, .apb_req_i, .apb_rsp_o,
    .done_snap_i(done_snap), .done_gray_i(done_gray), .done_edge_i(done_edge),
    .cmd_o(cmd), .busy_o(busy),
    .start_snap_o(start_snap), .start_gray_o(start_gray), .start_edge_o(start_edge),
    .rb_addr_o(rb_addr), .rb_sel_o(rb_sel), .rb_data_i(rb_data), .done_o
  );

  pixel_capture u_capture (
    .clk_100, .reset_global, .frame_start_i, .pix_valid_i, .pix_data_i,
    .enable_i(!busy), .wr_o(cap_wr)  // camera only lands in live mode
  );

  snapshot_copy u_snap (
    .clk_100, .reset_global, .start_i(start_snap),
    .rd_addr_o(snap_rd), .rd_data_i(buf1_q), .wr_o(snap_wr), .done_o(done_snap)
  );

  gray_filter u_gray (
    .clk_100, .reset_global, .start_i(start_gray),
    .rd_addr_o(gray_rd), .rd_data_i(buf2_q), .wr_o(gray_wr), .done_o(done_gray)
  );

  edge_filter u_edge (
    .clk_100, .reset_global, .start_i(start_edge),
    .rd_addr_o(edge_rd), .rd_data_i(buf2_q), .wr_o(edge_wr), .done_o(done_edge)
  );

  buffer_arbiter u_arb (
    .clk_100, .reset_global, .cmd_i(cmd), .busy_i(busy),
    .cap_wr_i(cap_wr),
    .snap_wr_i(snap_wr), .snap_rd_addr_i(snap_rd),
    .gray_wr_i(gray_wr), .gray_rd_addr_i(gray_rd),
    .edge_wr_i(edge_wr), .edge_rd_addr_i(edge_rd),
    .rb_addr_i(rb_addr), .rb_sel_i(rb_sel),
    .buf1_wr_o(buf1_wr), .buf1_rd_addr_o(buf1_rd),
    .buf2_wr_o(buf2_wr), .buf2_rd_addr_o(buf2_rd),
    .rd_data_o(rb_data), .buf1_data_i(buf1_q), .buf2_data_i(buf2_q)
  );

  frame_buffer u_buf1 (  // live frame
    .clk_100, .wr_i(buf1_wr), .rd_addr_i(buf1_rd), .rd_data_o(buf1_q)
  );

  frame_buffer u_buf2 (  // snapshot, filtered in place
    .clk_100, .wr_i(buf2_wr), .rd_addr_i(buf2_rd), .rd_data_o(buf2_q)
  );

endmodule

// File: testbench/tb_cam_top.sv
`timescale 1ns/100ps

module tb_cam_top;

  localparam int max_cycles = 5000;  // about twice the full sequence
  localparam int raw_f  = 0;
  localparam int alt_f  = 1;
  localparam int drop_f = 2;
  localparam int gray_f = 3;
  localparam int edge_f = 4;

  logic              clk_100;
  logic              reset_global;
  cam_pkg::apb_req_t apb_req;
  cam_pkg::apb_rsp_t apb_rsp;
  logic              frame_start;
  logic              pix_valid;
  cam_pkg::pix_t     pix_data;
  logic              done;

  cam_pkg::pix_t     file_words [3 * cam_pkg::pix_count];
  cam_pkg::pix_t     frames [5][cam_pkg::pix_count];  // raw, alt, dropped, gray, edge
  integer            seed;
  integer            rnd;
  integer            cycles;
  integer            n_checks;
  integer            n_errors;
  cam_pkg::apb_rsp_t rsp;

  cam_top dut (
    .clk_100, .reset_global, .apb_req_i(apb_req), .apb_rsp_o(apb_rsp),
    .frame_start_i(frame_start), .pix_valid_i(pix_valid), .pix_data_i(pix_data),
    .done_o(done)
  );

  always #4 clk_100 = ~clk_100;

  always @(posedge clk_100) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout after %0d cycles, the DUT never finished", max_cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_pix(input string name, input cam_pkg::pix_t got, input cam_pkg::pix_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_rsp(input string name, input cam_pkg::apb_rsp_t got, input logic exp_err);
    n_checks++;
    if (got.pslverr !== exp_err) begin
      n_errors++;
      $display("ERROR at %0t: %s pslverr is %b, expected %b", $time, name, got.pslverr, exp_err);
    end
  endtask

  task automatic check_status(input string name, input logic [1:0] got, input logic [1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // setup cycle then access cycles until pready is seen at a falling edge
  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                          output cam_pkg::apb_rsp_t r);
    @(posedge clk_100);
    #1;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk_100);
    #1;
    apb_req.penable = 1'b1;
    @(negedge clk_100);
    while (!apb_rsp.pready) begin
      @(negedge clk_100);
    end
    r = apb_rsp;
    @(posedge clk_100);
    #1;
    apb_req = '0;
  endtask

  task automatic feed_frame(input int f);
    integer r;
    @(posedge clk_100);
    #1;
    frame_start = 1'b1;
    @(posedge clk_100);
    #1;
    frame_start = 1'b0;
    for (int i = 0; i < cam_pkg::pix_count; i++) begin
      r = $random(seed);
      if (r[2:0] == 3'd0) begin  // idle gap now and then
        pix_valid = 1'b0;
        @(posedge clk_100);
        #1;
      end
      pix_valid = 1'b1;
      pix_data  = frames[f][i];
      @(posedge clk_100);
      #1;
    end
    pix_valid = 1'b0;
  endtask

  task automatic read_pixel(input logic sel, input int a, output cam_pkg::pix_t p);
    cam_pkg::apb_rsp_t r;
    apb_xfer(1'b1, cam_pkg::reg_pix_addr, {23'd0, sel, 8'(a)}, r);
    apb_xfer(1'b0, cam_pkg::reg_pix_data, 32'd0, r);
    p = r.prdata[11:0];
  endtask

  task automatic check_buffer(input logic sel, input int f, input string tag);
    cam_pkg::pix_t got;
    for (int i = 0; i < cam_pkg::pix_count; i++) begin
      read_pixel(sel, i, got);
      check_pix($sformatf("%s pixel %0d", tag, i), got, frames[f][i]);
    end
  endtask

  task automatic run_command(input cam_pkg::cam_cmd_e c);
    cam_pkg::apb_rsp_t r;
    apb_xfer(1'b1, cam_pkg::reg_ctrl, {30'd0, c}, r);
    check_rsp("ctrl write", r, 1'b0);
  endtask

  task automatic wait_done(input string tag);
    cam_pkg::apb_rsp_t r;
    r = '0;
    while (!r.prdata[1]) begin
      apb_xfer(1'b0, cam_pkg::reg_status, 32'd0, r);
    end
    check_status({tag, " status"}, r.prdata[1:0], 2'b10);  // idle and done
    check_flag("done_o", done, 1'b1);
  endtask

  initial begin
    clk_100      = 1'b0;
    reset_global = 1'b1;
    apb_req      = '0;
    frame_start  = 1'b0;
    pix_valid    = 1'b0;
    pix_data     = '0;
    seed         = 32'h0eb8_0798;
    cycles       = 0;
    n_checks     = 0;
    n_errors     = 0;

    $readmemh("testbench/cam_input.txt", file_words);
    if ($isunknown(file_words[3 * cam_pkg::pix_count - 1])) begin
      n_errors++;
      $display("could not read pixel data from testbench/cam_input.txt");
    end
    for (int i = 0; i < cam_pkg::pix_count; i++) begin
      frames[raw_f][i]  = file_words[3 * i];
      frames[gray_f][i] = file_words[3 * i + 1];
      frames[edge_f][i] = file_words[3 * i + 2];
      rnd               = $random(seed);
      frames[alt_f][i]  = rnd[11:0];
      rnd               = $random(seed);
      frames[drop_f][i] = rnd[11:0];
    end

    repeat (8) @(posedge clk_100);
    #1;
    reset_global = 1'b0;

    // idle after reset
    apb_xfer(1'b0, cam_pkg::reg_status, 32'd0, rsp);
    check_status("reset status", rsp.prdata[1:0], 2'b00);
    check_flag("done_o", done, 1'b0);
    @(negedge clk_100);
    check_flag("pready", apb_rsp.pready, 1'b0);

    // live capture into buffer 1
    feed_frame(raw_f);
    check_buffer(1'b0, raw_f, "buf1");

    // snapshot then a new live frame that must leave buffer 2 alone
    run_command(cam_pkg::cmd_snapshot);
    wait_done("snapshot");
    check_buffer(1'b1, raw_f, "buf2");
    feed_frame(alt_f);
    check_buffer(1'b1, raw_f, "buf2");
    check_buffer(1'b0, alt_f, "buf1");

    // gray pass with a refused command while busy
    feed_frame(raw_f);
    run_command(cam_pkg::cmd_snapshot);
    wait_done("snapshot");
    run_command(cam_pkg::cmd_gray);
    apb_xfer(1'b0, cam_pkg::reg_status, 32'd0, rsp);
    check_status("gray status", rsp.prdata[1:0], 2'b01);
    apb_xfer(1'b1, cam_pkg::reg_ctrl, {30'd0, cam_pkg::cmd_edge}, rsp);
    check_rsp("ctrl write while busy", rsp, 1'b1);
    wait_done("gray");
    check_buffer(1'b1, gray_f, "buf2 gray");

    // edge pass on a fresh copy; camera pixels arrive meanwhile
    run_command(cam_pkg::cmd_snapshot);
    wait_done("snapshot");
    run_command(cam_pkg::cmd_edge);
    fork
      feed_frame(drop_f);
      wait_done("edge");
    join
    check_buffer(1'b1, edge_f, "buf2 edge");
    check_buffer(1'b0, raw_f, "buf1");

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/cam_input.txt
// columns: raw rgb444 pixel, expected gray pixel, expected edge pixel
// one line per pixel, raster order, 8 wide by 4 high
000 000 666
111 111 eee
888 888 aaa
fff fff ddd
f00 333 555
0f0 777 666
00f 333 666
123 222 000
456 555 ddd
789 888 bbb
abc bbb 777
def eee fff
321 222 ccc
654 555 999
987 888 777
cba bbb 000
fff fff fff
000 000 fff
5a5 777 333
a5a 777 777
0ff bbb 444
ff0 bbb bbb
444 444 bbb
ccc ccc 000
000 000 000
fff fff 000
248 444 000
842 444 000
777 777 000
1e1 777 000
e1e 777 000
369 666 000

// File: src.f
verilog/cam_pkg.sv
verilog/frame_buffer.sv
verilog/pixel_capture.sv
verilog/snapshot_copy.sv
verilog/gray_filter.sv
verilog/edge_filter.sv
verilog/buffer_arbiter.sv
verilog/cam_apb_regs.sv
verilog/cam_top.sv
testbench/tb_cam_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_cam_top -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "^ALL CHECKS PASSED$"; then
  exit 0
fi
exit 1
